/* src/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word and register file sizes
`define DATA_WIDTH 16
`define REG_COUNT 16

// Memory depths, counted in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`endif

/* src/isaPkg.sv */
`include "cpu_params.svh"

package isaPkg;

	// Opcode in bits 15..12
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		RED    = 4'd2,
		XOR    = 4'd3,
		SLL    = 4'd4,
		SRA    = 4'd5,
		ROR    = 4'd6,
		PADDSB = 4'd7,
		LW     = 4'd8,
		SW     = 4'd9,
		LHB    = 4'd10,
		LLB    = 4'd11,
		B      = 4'd12,
		BR     = 4'd13,
		PCS    = 4'd14,
		HLT    = 4'd15
	} opcode;

	// Branch condition in bits 11..9 of B and BR
	typedef enum logic [2:0] {
		NE = 3'd0,
		EQ = 3'd1,
		GT = 3'd2,
		LT = 3'd3,
		GE = 3'd4,
		LE = 3'd5,
		OV = 3'd6,
		UN = 3'd7
	} condCode;

	typedef logic [`DATA_WIDTH-1:0] instrWord;
	typedef logic [7:0] imm8;
	typedef logic signed [8:0] branchOffset;

endpackage

/* src/datapathPkg.sv */
`include "cpu_params.svh"

package datapathPkg;

	typedef logic [`DATA_WIDTH-1:0] dataWord;
	typedef logic [$clog2(`REG_COUNT)-1:0] regIndex;
	typedef logic [$clog2(`DMEM_DEPTH)-1:0] memAddr;

	// Flag register, Z on top and N at the bottom
	typedef logic [2:0] aluFlags;

	localparam int flagZ = 2;
	localparam int flagV = 1;
	localparam int flagN = 0;

endpackage

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input  isaPkg::opcode instrOp,
	output logic          memRead,
	output logic          memToReg,
	output logic          memWrite,
	output logic          aluSrc,
	output logic          aluOp,
	output logic          regWrite,
	output logic          halt,
	output logic          pcSave,
	output logic          topHalf,
	output logic          branch,
	output logic          branchReg
);

	always_comb begin
		memRead = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		aluOp = 1'b0;
		regWrite = 1'b0;
		halt = 1'b0;
		pcSave = 1'b0;
		topHalf = 1'b0;
		branch = 1'b0;
		branchReg = 1'b0;
		case (instrOp)
			// Register-register ALU ops
			isaPkg::ADD, isaPkg::SUB, isaPkg::RED, isaPkg::XOR, isaPkg::PADDSB: begin
				regWrite = 1'b1;
				aluOp = 1'b1;
			end
			// Shifts take their amount from the immediate
			isaPkg::SLL, isaPkg::SRA, isaPkg::ROR: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				aluOp = 1'b1;
			end
			isaPkg::LW: begin
				memRead = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			isaPkg::SW: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			isaPkg::LHB: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				topHalf = 1'b1;
			end
			isaPkg::LLB: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			isaPkg::B: branch = 1'b1;
			isaPkg::BR: branchReg = 1'b1;
			isaPkg::PCS: begin
				regWrite = 1'b1;
				pcSave = 1'b1;
			end
			isaPkg::HLT: halt = 1'b1;
			default: ;
		endcase
		assert (!(memRead && memWrite)) else $error("load and store decoded together");
	end

endmodule

/* src/fetchUnit.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetchUnit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 loadEnable,
	input  datapathPkg::memAddr  loadAddr,
	input  isaPkg::instrWord     loadData,
	input  datapathPkg::aluFlags flags,
	input  logic                 branch,
	input  logic                 branchReg,
	input  logic                 halt,
	input  datapathPkg::dataWord branchTarget,
	output isaPkg::instrWord     instr,
	output datapathPkg::dataWord pc,
	output datapathPkg::dataWord pcNext,
	output logic                 halted
);

	isaPkg::instrWord imem [`IMEM_DEPTH];
	isaPkg::condCode cond;
	isaPkg::branchOffset offset;
	datapathPkg::dataWord pcPlusOne;
	datapathPkg::dataWord offsetTarget;
	logic condTrue;

	// Program is loaded only while the core is held in reset
	always_ff @(posedge clk) begin
		if (reset && loadEnable)
			imem[loadAddr] <= loadData;
	end

	assign instr = imem[datapathPkg::memAddr'(pc)];
	assign cond = isaPkg::condCode'(instr[11:9]);
	assign offset = instr[8:0];
	assign pcPlusOne = pc + 1'b1;
	assign offsetTarget = pcPlusOne + {{7{offset[8]}}, offset};

	always_comb begin
		case (cond)
			isaPkg::NE: condTrue = !flags[datapathPkg::flagZ];
			isaPkg::EQ: condTrue = flags[datapathPkg::flagZ];
			isaPkg::GT: condTrue = !flags[datapathPkg::flagZ] && !flags[datapathPkg::flagN];
			isaPkg::LT: condTrue = flags[datapathPkg::flagN];
			isaPkg::GE: condTrue = flags[datapathPkg::flagZ] || !flags[datapathPkg::flagN];
			isaPkg::LE: condTrue = flags[datapathPkg::flagZ] || flags[datapathPkg::flagN];
			isaPkg::OV: condTrue = flags[datapathPkg::flagV];
			default: condTrue = 1'b1;
		endcase
	end

	// HLT keeps the PC on itself
	always_comb begin
		if (halt)
			pcNext = pc;
		else if (branch && condTrue)
			pcNext = offsetTarget;
		else if (branchReg && condTrue)
			pcNext = branchTarget;
		else
			pcNext = pcPlusOne;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			pc <= pcNext;
			halted <= halt;
		end
	end

	assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc));

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module registerFile (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 writeEnable,
	input  datapathPkg::regIndex readIndexA,
	input  datapathPkg::regIndex readIndexB,
	input  datapathPkg::regIndex writeIndex,
	input  datapathPkg::dataWord writeData,
	output datapathPkg::dataWord readDataA,
	output datapathPkg::dataWord readDataB
);

	datapathPkg::dataWord regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeIndex != '0) begin
			regs[writeIndex] <= writeData;
		end
	end

	// Register 0 is hardwired to zero
	assign readDataA = (readIndexA == '0) ? '0 : regs[readIndexA];
	assign readDataB = (readIndexB == '0) ? '0 : regs[readIndexB];

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic                 clk,
	input  logic                 reset,
	input  isaPkg::opcode        instrOp,
	input  datapathPkg::dataWord operandA,
	input  datapathPkg::dataWord operandB,
	input  logic                 execute,
	output datapathPkg::dataWord result,
	output datapathPkg::aluFlags flags
);

	datapathPkg::dataWord sum;
	datapathPkg::dataWord diff;
	datapathPkg::dataWord satSum;
	datapathPkg::dataWord satDiff;
	logic sumOvf;
	logic diffOvf;
	logic overflow;
	logic [3:0] shamt;
	logic [31:0] rotWide;
	logic signed [9:0] redSum;

	// Signed nibble add clamped to -8..7
	function automatic logic [3:0] satAdd4(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] s;
		s = x + y;
		if (x[3] == y[3] && s[3] != x[3])
			return x[3] ? 4'b1000 : 4'b0111;
		return s;
	endfunction

	assign sum = operandA + operandB;
	assign diff = operandA - operandB;
	assign sumOvf = (operandA[15] == operandB[15]) && (sum[15] != operandA[15]);
	assign diffOvf = (operandA[15] != operandB[15]) && (diff[15] != operandA[15]);
	assign satSum = sumOvf ? (operandA[15] ? 16'h8000 : 16'h7fff) : sum;
	assign satDiff = diffOvf ? (operandA[15] ? 16'h8000 : 16'h7fff) : diff;
	assign shamt = operandB[3:0];
	assign rotWide = {operandA, operandA} >> shamt;
	assign redSum = $signed(operandA[15:8]) + $signed(operandA[7:0])
		+ $signed(operandB[15:8]) + $signed(operandB[7:0]);

	always_comb begin
		overflow = 1'b0;
		case (instrOp)
			isaPkg::ADD: begin
				result = satSum;
				overflow = sumOvf;
			end
			isaPkg::SUB: begin
				result = satDiff;
				overflow = diffOvf;
			end
			isaPkg::RED: result = {{6{redSum[9]}}, redSum};
			isaPkg::XOR: result = operandA ^ operandB;
			isaPkg::SLL: result = operandA << shamt;
			isaPkg::SRA: result = $signed(operandA) >>> shamt;
			isaPkg::ROR: result = rotWide[15:0];
			isaPkg::PADDSB: result = {satAdd4(operandA[15:12], operandB[15:12]),
				satAdd4(operandA[11:8], operandB[11:8]),
				satAdd4(operandA[7:4], operandB[7:4]),
				satAdd4(operandA[3:0], operandB[3:0])};
			// LW and SW address is a plain wrapping add
			default: result = sum;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (execute) begin
			case (instrOp)
				isaPkg::ADD, isaPkg::SUB: begin
					flags[datapathPkg::flagZ] <= (result == '0);
					flags[datapathPkg::flagV] <= overflow;
					flags[datapathPkg::flagN] <= result[15];
				end
				isaPkg::XOR, isaPkg::SLL, isaPkg::SRA, isaPkg::ROR:
					flags[datapathPkg::flagZ] <= (result == '0);
				default: ;
			endcase
		end
	end

endmodule

/* src/dataMemory.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module dataMemory (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 memRead,
	input  logic                 memWrite,
	input  logic                 enable,
	input  datapathPkg::memAddr  addr,
	input  datapathPkg::dataWord writeData,
	output datapathPkg::dataWord readData,
	output datapathPkg::dataWord storeData,
	output logic                 storeValid,
	output datapathPkg::memAddr  storeAddr
);

	datapathPkg::dataWord mem [`DMEM_DEPTH];

	assign readData = memRead ? mem[addr] : '0;

	// Store strobe mirrors the write that lands at the closing edge
	assign storeValid = enable && memWrite;
	assign storeAddr = addr;
	assign storeData = writeData;

	always_ff @(posedge clk) begin
		if (!reset && storeValid)
			mem[addr] <= writeData;
	end

endmodule

/* src/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 loadEnable,
	input  datapathPkg::memAddr  loadAddr,
	input  isaPkg::instrWord     loadData,
	output logic                 halted,
	output logic                 storeValid,
	output datapathPkg::memAddr  storeAddr,
	output datapathPkg::dataWord storeData
);

	isaPkg::instrWord instr;
	isaPkg::opcode op;
	isaPkg::imm8 immByte;
	datapathPkg::dataWord pc, pcNext;
	datapathPkg::dataWord regA, regB, immExt, aluB, aluResult, memData, writeBack;
	datapathPkg::regIndex readIndexA, readIndexB;
	datapathPkg::aluFlags flags;
	logic memRead, memToReg, memWrite, aluSrc, aluOp, regWrite;
	logic halt, pcSave, topHalf, branch, branchReg;
	logic execute;

	// Nothing commits during reset or after HLT
	assign execute = !halted && !reset;

	assign op = isaPkg::opcode'(instr[15:12]);
	assign immByte = instr[7:0];
	assign immExt = {{12{instr[3]}}, instr[3:0]};
	assign aluB = aluSrc ? immExt : regB;

	// LLB and LHB read back the destination, SW reads its data register
	assign readIndexA = (topHalf || op == isaPkg::LLB) ? instr[11:8] : instr[7:4];
	assign readIndexB = memWrite ? instr[11:8] : instr[3:0];

	always_comb begin
		if (memToReg)
			writeBack = memData;
		else if (pcSave)
			writeBack = pcNext;
		else if (topHalf)
			writeBack = {immByte, regA[7:0]};
		else if (op == isaPkg::LLB)
			writeBack = {regA[15:8], immByte};
		else
			writeBack = aluResult;
	end

	fetchUnit fetch0 (.clk(clk), .reset(reset), .loadEnable(loadEnable), .loadAddr(loadAddr),
		.loadData(loadData), .flags(flags), .branch(branch), .branchReg(branchReg),
		.halt(halt), .branchTarget(regA), .instr(instr), .pc(pc), .pcNext(pcNext),
		.halted(halted));

	controlUnit control0 (.instrOp(op), .memRead(memRead), .memToReg(memToReg),
		.memWrite(memWrite), .aluSrc(aluSrc), .aluOp(aluOp), .regWrite(regWrite),
		.halt(halt), .pcSave(pcSave), .topHalf(topHalf), .branch(branch),
		.branchReg(branchReg));

	registerFile regs0 (.clk(clk), .reset(reset), .writeEnable(regWrite && execute),
		.readIndexA(readIndexA), .readIndexB(readIndexB), .writeIndex(instr[11:8]),
		.writeData(writeBack), .readDataA(regA), .readDataB(regB));

	alu alu0 (.clk(clk), .reset(reset), .instrOp(op), .operandA(regA), .operandB(aluB),
		.execute(aluOp && execute), .result(aluResult), .flags(flags));

	dataMemory dmem0 (.clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite),
		.enable(execute), .addr(datapathPkg::memAddr'(aluResult)), .writeData(regB),
		.readData(memData), .storeData(storeData), .storeValid(storeValid),
		.storeAddr(storeAddr));

	// Halt latch in fetch must silence the store port
	assert property (@(posedge clk) disable iff (reset) halted |-> !storeValid);

	// Straight-line code moves the PC on by one word
	assert property (@(posedge clk) disable iff (reset)
		execute && !halt && !branch && !branchReg |=> pc == $past(pc) + 1'b1);

endmodule

/* bench/cpuBench.sv */
`timescale 1ns/1ps

module cpuBench;

	logic clk;
	logic reset;
	logic loadEnable;
	datapathPkg::memAddr loadAddr;
	isaPkg::instrWord loadData;
	logic halted;
	logic storeValid;
	datapathPkg::memAddr storeAddr;
	datapathPkg::dataWord storeData;

	logic [15:0] prog [$];
	logic [15:0] expAddr [$];
	logic [15:0] expData [$];
	logic [15:0] gotAddr [$];
	logic [15:0] gotData [$];

	cpuTop dut0 (.clk(clk), .reset(reset), .loadEnable(loadEnable), .loadAddr(loadAddr),
		.loadData(loadData), .halted(halted), .storeValid(storeValid),
		.storeAddr(storeAddr), .storeData(storeData));

	always #5 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual)
			abortRun($sformatf("error: %s expected %h actual %h", testName, expected, actual));
	endtask

	// Saturate a signed sum to the 16-bit range
	function automatic logic [15:0] clampWord(input int value);
		if (value > 32767)
			return 16'h7fff;
		if (value < -32768)
			return 16'h8000;
		return value[15:0];
	endfunction

	// Expected ALU result, written from the instruction set rules
	function automatic logic [15:0] aluModel(input isaPkg::opcode op, input logic [15:0] a,
		input logic [15:0] b);
		int total;
		int nib;
		logic [15:0] res;
		res = '0;
		case (op)
			isaPkg::ADD: res = clampWord(int'($signed(a)) + int'($signed(b)));
			isaPkg::SUB: res = clampWord(int'($signed(a)) - int'($signed(b)));
			isaPkg::XOR: res = a ^ b;
			isaPkg::SLL: res = a << b[3:0];
			isaPkg::SRA: begin
				total = int'($signed(a)) >>> b[3:0];
				res = total[15:0];
			end
			isaPkg::ROR: begin
				res = a;
				for (int i = 0; i < b[3:0]; i++)
					res = {res[0], res[15:1]};
			end
			isaPkg::RED: begin
				total = int'($signed(a[15:8])) + int'($signed(a[7:0]))
					+ int'($signed(b[15:8])) + int'($signed(b[7:0]));
				res = total[15:0];
			end
			isaPkg::PADDSB: begin
				for (int k = 0; k < 4; k++) begin
					nib = int'($signed(a[k*4 +: 4])) + int'($signed(b[k*4 +: 4]));
					if (nib > 7)
						nib = 7;
					if (nib < -8)
						nib = -8;
					res[k*4 +: 4] = nib[3:0];
				end
			end
			default: res = a + b;
		endcase
		return res;
	endfunction

	function automatic logic condHolds(input isaPkg::condCode cond, input logic z,
		input logic v, input logic n);
		case (cond)
			isaPkg::NE: return !z;
			isaPkg::EQ: return z;
			isaPkg::GT: return !z && !n;
			isaPkg::LT: return n;
			isaPkg::GE: return z || !n;
			isaPkg::LE: return z || n;
			isaPkg::OV: return v;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [15:0] encReg(input isaPkg::opcode op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	task automatic clearProgram();
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic loadConst(input logic [3:0] rd, input logic [15:0] value);
		prog.push_back({isaPkg::LLB, rd, value[7:0]});
		prog.push_back({isaPkg::LHB, rd, value[15:8]});
	endtask

	// SW plus the store it should produce
	task automatic storeWord(input logic [3:0] rt, input logic [3:0] rs, input logic [3:0] imm,
		input logic [15:0] baseValue, input logic [15:0] value);
		prog.push_back({isaPkg::SW, rt, rs, imm});
		expAddr.push_back((baseValue + {{12{imm[3]}}, imm}) & 16'h00ff);
		expData.push_back(value);
	endtask

	// Core sits in reset while the program goes into instruction memory
	task automatic loadProgram();
		int cycles;
		cycles = (prog.size() > 10) ? prog.size() : 10;
		@(posedge clk);
		reset <= 1'b1;
		loadEnable <= 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			loadEnable <= (i < prog.size());
			loadAddr <= datapathPkg::memAddr'(i);
			loadData <= (i < prog.size()) ? prog[i] : 16'h0;
		end
	endtask

	task automatic runProgram(input string testName);
		int waited;
		gotAddr.delete();
		gotData.delete();
		loadProgram();
		@(posedge clk);
		reset <= 1'b0;
		loadEnable <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			if (storeValid) begin
				gotAddr.push_back(16'(storeAddr));
				gotData.push_back(storeData);
			end
			waited++;
			if (waited > 2000)
				abortRun($sformatf("%s: core did not halt within 2000 cycles", testName));
		end while (!halted);
		// Core must stay quiet once halted
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			if (storeValid)
				abortRun($sformatf("%s: store appeared after HLT", testName));
			if (!halted)
				abortRun($sformatf("%s: halted dropped before reset", testName));
		end
		if (gotAddr.size() < expAddr.size())
			abortRun($sformatf("%s: only %0d of %0d expected stores appeared", testName,
				gotAddr.size(), expAddr.size()));
		if (gotAddr.size() > expAddr.size())
			abortRun($sformatf("%s: %0d stores seen but only %0d expected", testName,
				gotAddr.size(), expAddr.size()));
		foreach (expAddr[i]) begin
			checkValue($sformatf("%s store %0d address", testName, i), expAddr[i], gotAddr[i]);
			checkValue($sformatf("%s store %0d data", testName, i), expData[i], gotData[i]);
		end
	endtask

	task automatic testArithmetic();
		logic [15:0] a [8];
		logic [15:0] b [8];
		isaPkg::opcode ops [3] = '{isaPkg::ADD, isaPkg::SUB, isaPkg::XOR};
		for (int i = 0; i < 4; i++) begin
			a[i] = 16'($urandom());
			b[i] = 16'($urandom());
		end
		// Saturation toward both limits
		a[4] = 16'h7000;
		b[4] = 16'h7000;
		a[5] = 16'h9000;
		b[5] = 16'h9000;
		a[6] = 16'h7fff;
		b[6] = 16'h8000;
		a[7] = 16'h8000;
		b[7] = 16'h0001;
		clearProgram();
		for (int i = 0; i < 8; i++) begin
			loadConst(4'd1, a[i]);
			loadConst(4'd2, b[i]);
			foreach (ops[k]) begin
				prog.push_back(encReg(ops[k], 4'(k + 3), 4'd1, 4'd2));
				storeWord(4'(k + 3), 4'd0, 4'(k), 16'd0, aluModel(ops[k], a[i], b[i]));
			end
		end
		prog.push_back({isaPkg::HLT, 12'd0});
		runProgram("testArithmetic");
	endtask

	task automatic testShiftPacked();
		isaPkg::opcode ops [5] = '{isaPkg::SLL, isaPkg::SRA, isaPkg::ROR, isaPkg::RED,
			isaPkg::PADDSB};
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] opB;
		logic [3:0] field;
		clearProgram();
		for (int i = 0; i < 4; i++) begin
			a = 16'($urandom());
			b = 16'($urandom());
			loadConst(4'd1, a);
			loadConst(4'd2, b);
			foreach (ops[k]) begin
				// Shifts carry their amount in the low nibble
				if (k < 3) begin
					field = 4'($urandom());
					opB = {{12{field[3]}}, field};
				end else begin
					field = 4'd2;
					opB = b;
				end
				prog.push_back(encReg(ops[k], 4'd3, 4'd1, field));
				storeWord(4'd3, 4'd0, 4'(k), 16'd0, aluModel(ops[k], a, opB));
			end
		end
		prog.push_back({isaPkg::HLT, 12'd0});
		runProgram("testShiftPacked");
	endtask

	task automatic testMemory();
		logic [15:0] words [4];
		logic [3:0] offs [4] = '{4'h0, 4'h3, 4'hc, 4'h7};
		logic [15:0] baseStore;
		logic [15:0] baseCopy;
		clearProgram();
		baseStore = 16'd32 + 16'($urandom() % 64);
		baseCopy = 16'd160 + 16'($urandom() % 64);
		loadConst(4'd5, baseStore);
		loadConst(4'd7, baseCopy);
		// Offset 4'hc reaches below the base
		for (int k = 0; k < 4; k++) begin
			words[k] = 16'($urandom());
			loadConst(4'(k + 1), words[k]);
			storeWord(4'(k + 1), 4'd5, offs[k], baseStore, words[k]);
		end
		for (int k = 0; k < 4; k++) begin
			prog.push_back({isaPkg::LW, 4'd6, 4'd5, offs[k]});
			storeWord(4'd6, 4'd7, 4'(k), baseCopy, words[k]);
		end
		prog.push_back({isaPkg::HLT, 12'd0});
		runProgram("testMemory");
	endtask

	task automatic testBranches();
		isaPkg::opcode flagOp [4] = '{isaPkg::ADD, isaPkg::ADD, isaPkg::SUB, isaPkg::ADD};
		logic [3:0] srcA [4] = '{4'd0, 4'd1, 4'd1, 4'd3};
		logic [3:0] srcB [4] = '{4'd0, 4'd1, 4'd2, 4'd1};
		logic [15:0] regVal [4] = '{16'h0000, 16'h0001, 16'h0002, 16'h7fff};
		logic [15:0] res;
		logic [15:0] wrap;
		logic z;
		logic v;
		logic n;
		clearProgram();
		loadConst(4'd1, regVal[1]);
		loadConst(4'd2, regVal[2]);
		loadConst(4'd3, regVal[3]);
		loadConst(4'd12, 16'h00aa);
		loadConst(4'd13, 16'h0055);
		for (int c = 0; c < 8; c++) begin
			for (int f = 0; f < 4; f++) begin
				prog.push_back(encReg(flagOp[f], 4'd9, srcA[f], srcB[f]));
				res = aluModel(flagOp[f], regVal[srcA[f]], regVal[srcB[f]]);
				if (flagOp[f] == isaPkg::ADD)
					wrap = regVal[srcA[f]] + regVal[srcB[f]];
				else
					wrap = regVal[srcA[f]] - regVal[srcB[f]];
				z = (res == 16'h0);
				n = res[15];
				v = (res != wrap);
				// Taken skips the 0x55 marker, fall-through jumps over 0xaa
				prog.push_back({isaPkg::B, 3'(c), 9'd2});
				prog.push_back({isaPkg::SW, 4'd13, 4'd0, 4'd0});
				prog.push_back({isaPkg::B, isaPkg::UN, 9'd1});
				prog.push_back({isaPkg::SW, 4'd12, 4'd0, 4'd0});
				expAddr.push_back(16'h0);
				expData.push_back(condHolds(isaPkg::condCode'(c), z, v, n) ? 16'h00aa : 16'h0055);
			end
		end
		prog.push_back({isaPkg::HLT, 12'd0});
		runProgram("testBranches");
	endtask

	task automatic testPcsBrHalt();
		clearProgram();
		prog.push_back({isaPkg::PCS, 4'd1, 8'd0});
		storeWord(4'd1, 4'd0, 4'd2, 16'd0, 16'(prog.size()));
		// Jump target at word 11, decoy HLT at word 10
		loadConst(4'd2, 16'd11);
		loadConst(4'd4, 16'd10);
		prog.push_back({isaPkg::PCS, 4'd3, 8'd0});
		prog.push_back({isaPkg::BR, isaPkg::EQ, 1'b0, 4'd4, 4'd0});
		prog.push_back({isaPkg::BR, isaPkg::UN, 1'b0, 4'd2, 4'd0});
		prog.push_back({isaPkg::SW, 4'd1, 4'd0, 4'd3});
		prog.push_back({isaPkg::HLT, 12'd0});
		storeWord(4'd3, 4'd0, 4'd4, 16'd0, 16'd7);
		prog.push_back({isaPkg::HLT, 12'd0});
		runProgram("testPcsBrHalt");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		loadEnable = 1'b0;
		loadAddr = '0;
		loadData = '0;
		void'($urandom(32'hb6e961d0));
		testArithmetic();
		testShiftPacked();
		testMemory();
		testBranches();
		testPcsBrHalt();
		$display("All tests passed!");
		$finish;
	end

endmodule

/* project.f */
+incdir+src
src/isaPkg.sv
src/datapathPkg.sv
src/controlUnit.sv
src/fetchUnit.sv
src/registerFile.sv
src/alu.sv
src/dataMemory.sv
src/cpuTop.sv
bench/cpuBench.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module cpuBench \
	&& ./obj_dir/VcpuBench > sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
